// File: src/jt12_pkg.sv
package jt12_pkg;

    // External cen pulses per internal FM clock enable
    localparam int CEN_DIV    = 6;
    // clk_en ticks that busy stays high after a data write
    localparam int BUSY_TICKS = 32;
    // clk_en ticks per timer B count
    localparam int TMRB_PRE   = 16;

    localparam int TMRA_W = 10; // Timer A width
    localparam int TMRB_W = 8;  // Timer B width

    // Timer register numbers in part I
    localparam logic [7:0] REG_TMRA_HI = 8'h24; // Timer A bits 9..2
    localparam logic [7:0] REG_TMRA_LO = 8'h25; // Timer A bits 1..0
    localparam logic [7:0] REG_TMRB    = 8'h26;
    localparam logic [7:0] REG_TMR_CTL = 8'h27;

    // Bit positions in the timer control register
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_IRQ_A  = 2;
    localparam int CTL_IRQ_B  = 3;
    localparam int CTL_CLR_A  = 4;
    localparam int CTL_CLR_B  = 5;

    // Timer setup as held by the register decoder
    typedef struct packed {
        logic [TMRA_W-1:0] value_a;
        logic [TMRB_W-1:0] value_b;
        logic              load_a;
        logic              load_b;
        logic              irq_en_a;
        logic              irq_en_b;
    } tmr_cfg_t;

    // One-clock flag clear strobes
    typedef struct packed {
        logic clr_a;
        logic clr_b;
    } tmr_clr_t;

    // Overflow flags back to the status byte
    typedef struct packed {
        logic flag_a;
        logic flag_b;
    } tmr_flags_t;

endpackage

// File: src/jt12_cen_div.sv
`timescale 1ns/100ps

module jt12_cen_div import jt12_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic cen,
    output logic clk_en
);

    logic [$clog2(CEN_DIV)-1:0] cnt;

    // Counts cen pulses only, wraps every CEN_DIV of them
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt    <= '0;
            clk_en <= 1'b0;
        end else if (cen) begin
            if (cnt == CEN_DIV - 1) begin
                cnt    <= '0;
                clk_en <= 1'b1; // Single clk wide
            end else begin
                cnt    <= cnt + 1'b1;
                clk_en <= 1'b0;
            end
        end else begin
            clk_en <= 1'b0;
        end
    end

    // Divider must never produce back-to-back enables
    a_clk_en_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        clk_en |=> !clk_en
    ) else $error("clk_en high on two consecutive clocks");

endmodule

// File: src/jt12_timer.sv
`timescale 1ns/100ps

module jt12_timer #(
    parameter int CNT_W = 10
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             tick,
    input  logic [CNT_W-1:0] value,
    input  logic             load,
    input  logic             irq_en,
    input  logic             clr,
    output logic             flag
);

    logic [CNT_W-1:0] cnt;
    logic             overflow;

    // Counter at its top value on a running tick
    assign overflow = load && tick && (cnt == '1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (!load) begin
            cnt <= value; // Stopped timer sits at its start value
        end else if (tick) begin
            if (overflow) begin
                cnt <= value;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Sticky overflow flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= 1'b0;
        end else if (clr) begin
            flag <= 1'b0; // Clear wins over a set in the same cycle
        end else if (overflow && irq_en) begin
            flag <= 1'b1;
        end
    end

    // Flag needs the enable at the overflow that sets it
    a_flag_needs_en: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(flag) |-> $past(irq_en)
    ) else $error("timer flag rose with irq enable low");

endmodule

// File: src/jt12_mmr.sv
`timescale 1ns/100ps

module jt12_mmr import jt12_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       clk_en,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    input  tmr_flags_t flags,
    output tmr_cfg_t   cfg,
    output tmr_clr_t   clr,
    output logic [7:0] dout
);

    logic       write;
    logic       addr_wr;
    logic       data_wr;
    logic [7:0] reg_sel;   // Latched register number
    logic       busy;
    logic [$clog2(BUSY_TICKS)-1:0] busy_cnt;

    assign write   = !cs_n && !wr_n;
    // Part II (addr[1] high) is not decoded
    assign addr_wr = write && (addr == 2'b00);
    assign data_wr = write && (addr == 2'b01);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_sel <= '0;
        end else if (addr_wr) begin
            reg_sel <= din;
        end
    end

    // Timer registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= '0;
            clr <= '0;
        end else begin
            clr <= '0; // Clear bits only strobe
            if (data_wr) begin
                case (reg_sel)
                    REG_TMRA_HI: cfg.value_a[TMRA_W-1:2] <= din;
                    REG_TMRA_LO: cfg.value_a[1:0]        <= din[1:0];
                    REG_TMRB:    cfg.value_b             <= din;
                    REG_TMR_CTL: begin
                        cfg.load_a   <= din[CTL_LOAD_A];
                        cfg.load_b   <= din[CTL_LOAD_B];
                        cfg.irq_en_a <= din[CTL_IRQ_A];
                        cfg.irq_en_b <= din[CTL_IRQ_B];
                        clr.clr_a    <= din[CTL_CLR_A];
                        clr.clr_b    <= din[CTL_CLR_B];
                    end
                    default: ; // FM registers are not implemented
                endcase
            end
        end
    end

    // Busy window, restarted by every data write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= '0;
        end else if (busy && clk_en) begin
            busy_cnt <= busy_cnt + 1'b1;
            if (busy_cnt == BUSY_TICKS - 1) begin
                busy <= 1'b0; // Last tick of the window
            end
        end
    end

    // Status byte, one clock behind its sources
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout <= '0;
        end else begin
            dout <= {busy, 5'd0, flags.flag_b, flags.flag_a};
        end
    end

    // Busy can only be started by the bus
    a_busy_rise: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(busy) |-> $past(data_wr)
    ) else $error("busy rose without a data write");

endmodule

// File: src/jt12_timers.sv
`timescale 1ns/100ps

module jt12_timers import jt12_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       clk_en,
    input  tmr_cfg_t   cfg,
    input  tmr_clr_t   clr,
    output tmr_flags_t flags,
    output logic       irq_n
);

    logic [$clog2(TMRB_PRE)-1:0] pre_cnt;
    logic                        tick_b;
    logic                        flag_a;
    logic                        flag_b;

    // Timer B prescaler, runs on clk_en
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt <= '0;
        end else if (clk_en) begin
            pre_cnt <= (pre_cnt == TMRB_PRE - 1) ? '0 : pre_cnt + 1'b1;
        end
    end

    assign tick_b = clk_en && (pre_cnt == TMRB_PRE - 1);

    jt12_timer #(.CNT_W(TMRA_W)) u_tmr_a (
        .clk    ( clk          ),
        .arst_n ( arst_n       ),
        .tick   ( clk_en       ),
        .value  ( cfg.value_a  ),
        .load   ( cfg.load_a   ),
        .irq_en ( cfg.irq_en_a ),
        .clr    ( clr.clr_a    ),
        .flag   ( flag_a       )
    );

    jt12_timer #(.CNT_W(TMRB_W)) u_tmr_b (
        .clk    ( clk          ),
        .arst_n ( arst_n       ),
        .tick   ( tick_b       ), // 16x slower than timer A
        .value  ( cfg.value_b  ),
        .load   ( cfg.load_b   ),
        .irq_en ( cfg.irq_en_b ),
        .clr    ( clr.clr_b    ),
        .flag   ( flag_b       )
    );

    assign flags = '{flag_a: flag_a, flag_b: flag_b};

    // Open-drain style request, low while any flag is up
    assign irq_n = !(flag_a || flag_b);

endmodule

// File: src/jt12_top.sv
`timescale 1ns/100ps

module jt12_top import jt12_pkg::*; (
    input  logic       clk,    // CPU clock
    input  logic       arst_n,
    input  logic       cen,    // External clock enable, tie high if unused
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,   // Status byte
    output logic       irq_n
);

    logic       clk_en;
    tmr_cfg_t   cfg;
    tmr_clr_t   clr;
    tmr_flags_t flags;

    // Internal FM rate
    jt12_cen_div u_cen_div (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cen    ( cen    ),
        .clk_en ( clk_en )
    );

    // Bus side: address latch, timer registers, busy and status
    jt12_mmr u_mmr (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .clk_en ( clk_en ),
        .din    ( din    ),
        .addr   ( addr   ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .flags  ( flags  ),
        .cfg    ( cfg    ),
        .clr    ( clr    ),
        .dout   ( dout   )
    );

    jt12_timers u_timers (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .clk_en ( clk_en ),
        .cfg    ( cfg    ),
        .clr    ( clr    ),
        .flags  ( flags  ),
        .irq_n  ( irq_n  )
    );

endmodule

// File: verification/jt12_tb.sv
`timescale 1ns/100ps

module jt12_tb;

    // Chip constants
    localparam int CEN_DIV      = 6;
    localparam int BUSY_TICKS   = 32;
    localparam int TMRB_PRE     = 16;
    localparam int RESET_CYCLES = 10;
    localparam int NROWS        = 7;

    localparam logic [7:0] REG_TMRA_HI = 8'h24;
    localparam logic [7:0] REG_TMRA_LO = 8'h25;
    localparam logic [7:0] REG_TMRB    = 8'h26;
    localparam logic [7:0] REG_TMR_CTL = 8'h27;

    // Clock of the dout[7] fall counted from the data write edge
    localparam int BUSY_MIN = (BUSY_TICKS - 1) * CEN_DIV + 2;
    localparam int BUSY_MAX = BUSY_TICKS * CEN_DIV + 1;

    // One timer scenario. sel 0 is timer A, 1 is timer B
    typedef struct packed {
        logic       sel;
        logic [9:0] value;
        logic       load;
        logic       irq_en;
        logic       exp_flag;
    } row_t;

    logic       clk;
    logic       arst_n;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;

    row_t rows [NROWS];
    int   cycle_cnt;
    int   cycle_limit;

    jt12_top u_jt12_top (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cen    ( cen    ),
        .din    ( din    ),
        .addr   ( addr   ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .dout   ( dout   ),
        .irq_n  ( irq_n  )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    // Expected overflow period in clk cycles
    function automatic int row_period(input row_t r);
        if (r.sel)
            return (256 - r.value[7:0]) * TMRB_PRE * CEN_DIV;
        return (1024 - r.value) * CEN_DIV;
    endfunction

    // Phase uncertainty of the first tick
    function automatic int row_window(input row_t r);
        return r.sel ? TMRB_PRE * CEN_DIV : CEN_DIV;
    endfunction

    function automatic int calc_limit();
        int total;
        int hi;
        total = RESET_CYCLES + 2 * BUSY_MAX;
        for (int i = 0; i < NROWS; i++) begin
            hi = row_period(rows[i]) + row_window(rows[i]);
            total += rows[i].load ? hi : 2 * hi;
            total += BUSY_MAX + 20; // Bus writes around each row
        end
        return 2 * total;
    endfunction

    task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
            $display("=== FAIL ===");
            $fatal(1, "Value check failed");
        end
    endtask

    task automatic check_range(input string name, input int got, input int lo, input int hi);
        assert (got >= lo && got <= hi) else begin
            $display("Fail at %0t ns: %s expected %0d..%0d got %0d", $time, name, lo, hi, got);
            $display("=== FAIL ===");
            $fatal(1, "Range check failed");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Address write then data write of one clock each
    task automatic bus_write(input logic [7:0] reg_num, input logic [7:0] data);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'd0;
        din  = reg_num;
        next_cycle();
        addr = 2'd1;
        din  = data;
        next_cycle();
        cs_n = 1'b1;
        wr_n = 1'b1;
        din  = 8'h00;
    endtask

    task automatic check_busy();
        int n;
        bus_write(REG_TMR_CTL, 8'h30);
        next_cycle();
        n = 1;
        check_eq("dout[7]", dout[7], 1'b1);
        while (dout[7] !== 1'b0 && n < BUSY_MAX) begin
            next_cycle();
            n++;
        end
        check_eq("dout[7]", dout[7], 1'b0);
        check_range("busy length", n, BUSY_MIN, BUSY_MAX);
    endtask

    task automatic run_row(input row_t r);
        int         lo;
        int         hi;
        int         n;
        int         wait_n;
        logic [7:0] ctl;
        string      name;
        lo   = row_period(r) - row_window(r);
        hi   = row_period(r) + row_window(r);
        name = r.sel ? "dout[1]" : "dout[0]";
        bus_write(REG_TMR_CTL, 8'h30); // Stop both and clear both flags
        if (r.sel) begin
            bus_write(REG_TMRB, r.value[7:0]);
        end else begin
            bus_write(REG_TMRA_HI, r.value[9:2]);
            bus_write(REG_TMRA_LO, {6'd0, r.value[1:0]});
        end
        ctl = 8'h00;
        ctl[r.sel]     = r.load;
        ctl[2 + r.sel] = r.irq_en;
        bus_write(REG_TMR_CTL, ctl);
        if (r.exp_flag) begin
            n = 0;
            while (dout[r.sel] !== 1'b1 && n < hi) begin
                next_cycle();
                n++;
                if (n < lo) begin
                    check_eq("irq_n", irq_n, 1'b1);
                end
            end
            check_eq(name, dout[r.sel], 1'b1);
            check_range({name, " rise cycle"}, n, lo, hi);
            check_eq("irq_n", irq_n, 1'b0);
            ctl[4 + r.sel] = 1'b1; // Clear the flag and keep running
            bus_write(REG_TMR_CTL, ctl);
            repeat (2) next_cycle();
            check_eq(name, dout[r.sel], 1'b0);
            check_eq("irq_n", irq_n, 1'b1);
        end else begin
            wait_n = r.load ? hi : 2 * hi; // Stopped timer gets two periods
            repeat (wait_n) begin
                next_cycle();
                check_eq("dout[1:0]", {6'd0, dout[1:0]}, 8'h00);
                check_eq("irq_n", irq_n, 1'b1);
            end
        end
    endtask

    task automatic fill_table();
        rows[0] = {1'b0, 10'd1000, 1'b1, 1'b1, 1'b1};
        rows[1] = {1'b0, 10'd1012, 1'b1, 1'b0, 1'b0}; // Enable low
        rows[2] = {1'b1, 10'd250,  1'b1, 1'b1, 1'b1};
        rows[3] = {1'b1, 10'd252,  1'b1, 1'b0, 1'b0};
        rows[4] = {1'b0, 10'd1016, 1'b0, 1'b1, 1'b0}; // Load cleared
        rows[5] = {1'b1, 10'd254,  1'b0, 1'b1, 1'b0};
        rows[6] = {1'b0, 10'd1008, 1'b1, 1'b1, 1'b1};
    endtask

    initial begin
        arst_n      = 1'b0;
        cen         = 1'b1;
        din         = 8'h00;
        addr        = 2'd0;
        cs_n        = 1'b1;
        wr_n        = 1'b1;
        cycle_cnt   = 0;
        cycle_limit = 0;
        fill_table();
        cycle_limit = calc_limit();

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        next_cycle();
        check_eq("dout", dout, 8'h00);
        check_eq("irq_n", irq_n, 1'b1);

        check_busy();
        for (int i = 0; i < NROWS; i++) begin
            run_row(rows[i]);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: flist.f
src/jt12_pkg.sv
src/jt12_cen_div.sv
src/jt12_timer.sv
src/jt12_mmr.sv
src/jt12_timers.sv
src/jt12_top.sv
verification/jt12_tb.sv

// File: Bender.yml
package:
  name: jt12_timer_only

sources:
  - files:
      - src/jt12_pkg.sv
      - src/jt12_cen_div.sv
      - src/jt12_timer.sv
      - src/jt12_mmr.sv
      - src/jt12_timers.sv
      - src/jt12_top.sv
  - target: test
    files:
      - verification/jt12_tb.sv
